//--- bp_predict.f
design/rv_isa_pkg.sv
design/bp_pkg.sv
design/bp_update_if.sv
design/btb.sv
design/local_predictor.sv
design/bp_control.sv
design/bp_top.sv
testbench/bp_properties.sv
testbench/tb_bp_top.sv

//--- design/bp_control.sv
`timescale 1ns/1ns
`default_nettype none

module bp_control (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      lookup_valid,
  input  logic [bp_pkg::ADDR_W-1:0] lookup_instr,
  input  logic                      resolve_valid,
  input  logic [bp_pkg::ADDR_W-1:0] resolve_instr,
  input  logic                      resolve_taken,
  input  logic [bp_pkg::ADDR_W-1:0] resolve_target,
  output logic                      lookup_en,
  output bp_pkg::bp_key_u           lookup_key,
  input  logic                      btb_hit,
  input  logic [bp_pkg::ADDR_W-1:0] btb_target,
  input  logic                      cnt_taken,
  output logic                      pred_valid,
  output logic                      pred_taken,
  output logic [bp_pkg::ADDR_W-1:0] pred_target,
  bp_update_if.source               upd
);
  import rv_isa_pkg::*;
  import bp_pkg::*;

  br_kind_t lookup_kind;
  br_kind_t resolve_kind;
  br_kind_t kind_q;  // kind of the lookup now being answered

  function automatic br_kind_t classify(input logic [ADDR_W-1:0] instr);
    opcode_t op;
    op = opcode_t'(instr[OPCODE_W-1:0]);
    case (op)
      op_branch:       return kind_cond;
      op_jal, op_jalr: return kind_uncond;
      default:         return kind_none;
    endcase
  endfunction

  assign lookup_kind  = lookup_valid ? classify(lookup_instr) : kind_none;
  assign resolve_kind = resolve_valid ? classify(resolve_instr) : kind_none;

  assign lookup_en  = (lookup_kind != kind_none);
  assign lookup_key = lookup_instr[ADDR_W-1:KEY_LSB];

  // resolve path goes straight to both tables
  assign upd.upd_valid  = (resolve_kind != kind_none);
  assign upd.upd_key    = resolve_instr[ADDR_W-1:KEY_LSB];
  assign upd.upd_taken  = resolve_taken;
  assign upd.upd_target = resolve_target;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      kind_q <= kind_none;
    else
      kind_q <= lookup_kind;  // lines up with table read latency
  end

  always_comb
  begin
    case (kind_q)
      kind_uncond: pred_taken = btb_hit;
      kind_cond:   pred_taken = btb_hit & cnt_taken;
      default:     pred_taken = 1'b0;
    endcase
  end

  assign pred_valid  = (kind_q != kind_none);
  assign pred_target = pred_taken ? btb_target : '0;

endmodule

`default_nettype wire

//--- design/bp_pkg.sv
`default_nettype none

package bp_pkg;

  localparam int ADDR_W      = 32;
  localparam int KEY_W       = ADDR_W - rv_isa_pkg::KEY_LSB;  // 24
  localparam int BTB_INDEX_W = 10;
  localparam int BTB_TAG_W   = KEY_W - BTB_INDEX_W;  // 14
  localparam int HIST_W      = 4;
  localparam int CNT_W       = 2;

  localparam int BTB_DEPTH = 1 << BTB_INDEX_W;
  localparam int LHT_DEPTH = 1 << HIST_W;
  localparam int LPT_DEPTH = 1 << HIST_W;  // indexed by a history entry

  typedef struct packed {
    logic [BTB_TAG_W-1:0]   tag;
    logic [BTB_INDEX_W-1:0] index;
  } btb_view_t;

  typedef struct packed {
    logic [KEY_W-HIST_W-1:0] upper;
    logic [HIST_W-1:0]       index;
  } hist_view_t;

  // one key, split differently by each table
  typedef union packed {
    btb_view_t  btb;
    hist_view_t hist;
  } bp_key_u;

  typedef enum logic [1:0] {
    kind_none   = 2'd0,
    kind_cond   = 2'd1,
    kind_uncond = 2'd2
  } br_kind_t;

endpackage

`default_nettype wire

//--- design/bp_top.sv
`timescale 1ns/1ns
`default_nettype none

module bp_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      lookup_valid,
  input  logic [bp_pkg::ADDR_W-1:0] lookup_instr,
  input  logic                      resolve_valid,
  input  logic [bp_pkg::ADDR_W-1:0] resolve_instr,
  input  logic                      resolve_taken,
  input  logic [bp_pkg::ADDR_W-1:0] resolve_target,
  output logic                      pred_valid,
  output logic                      pred_taken,
  output logic [bp_pkg::ADDR_W-1:0] pred_target
);
  import bp_pkg::*;

  logic              lookup_en;
  bp_key_u           lookup_key;
  logic              btb_hit;
  logic [ADDR_W-1:0] btb_target;
  logic              cnt_taken;

  bp_update_if upd_bus ();

  bp_control u_control (
    .clk            (clk),
    .rst            (rst),
    .lookup_valid   (lookup_valid),
    .lookup_instr   (lookup_instr),
    .resolve_valid  (resolve_valid),
    .resolve_instr  (resolve_instr),
    .resolve_taken  (resolve_taken),
    .resolve_target (resolve_target),
    .lookup_en      (lookup_en),
    .lookup_key     (lookup_key),
    .btb_hit        (btb_hit),
    .btb_target     (btb_target),
    .cnt_taken      (cnt_taken),
    .pred_valid     (pred_valid),
    .pred_taken     (pred_taken),
    .pred_target    (pred_target),
    .upd            (upd_bus.source)
  );

  btb u_btb (
    .clk        (clk),
    .rst        (rst),
    .lookup_en  (lookup_en),
    .lookup_key (lookup_key),
    .upd        (upd_bus.sink),
    .hit        (btb_hit),
    .target     (btb_target)
  );

  local_predictor u_lpred (
    .clk        (clk),
    .rst        (rst),
    .lookup_en  (lookup_en),
    .lookup_key (lookup_key),
    .upd        (upd_bus.sink),
    .taken      (cnt_taken)
  );

endmodule

`default_nettype wire

//--- design/bp_update_if.sv
`timescale 1ns/1ns
`default_nettype none

interface bp_update_if;
  import bp_pkg::*;

  logic              upd_valid;  // one-cycle strobe
  bp_key_u           upd_key;
  logic              upd_taken;
  logic [ADDR_W-1:0] upd_target;

  modport source (
    output upd_valid, upd_key, upd_taken, upd_target
  );

  modport sink (
    input upd_valid, upd_key, upd_taken, upd_target
  );

endinterface

`default_nettype wire

//--- design/btb.sv
`timescale 1ns/1ns
`default_nettype none

module btb (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      lookup_en,
  input  bp_pkg::bp_key_u           lookup_key,
  bp_update_if.sink                 upd,
  output logic                      hit,
  output logic [bp_pkg::ADDR_W-1:0] target
);
  import bp_pkg::*;

  logic [BTB_DEPTH-1:0]   valid_q;
  logic [BTB_TAG_W-1:0]   tag_mem    [BTB_DEPTH];
  logic [ADDR_W-1:0]      target_mem [BTB_DEPTH];

  logic [BTB_INDEX_W-1:0] rd_idx;
  logic [BTB_INDEX_W-1:0] wr_idx;
  logic                   rd_match;

  assign rd_idx   = lookup_key.btb.index;
  assign wr_idx   = upd.upd_key.btb.index;
  assign rd_match = valid_q[rd_idx] && (tag_mem[rd_idx] == lookup_key.btb.tag);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_q <= '0;
      hit     <= 1'b0;
    end
    else
    begin
      if (upd.upd_valid)
        valid_q[wr_idx] <= 1'b1;
      if (lookup_en)
        hit <= rd_match;  // old contents on a same-cycle write
    end
  end

  // tag and target storage
  always_ff @(posedge clk)
  begin
    if (upd.upd_valid)
    begin
      tag_mem[wr_idx]    <= upd.upd_key.btb.tag;
      target_mem[wr_idx] <= upd.upd_target;
    end
    if (lookup_en)
      target <= target_mem[rd_idx];
  end

endmodule

`default_nettype wire

//--- design/local_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module local_predictor (
  input  logic            clk,
  input  logic            rst,
  input  logic            lookup_en,
  input  bp_pkg::bp_key_u lookup_key,
  bp_update_if.sink       upd,
  output logic            taken
);
  import bp_pkg::*;

  localparam logic [CNT_W-1:0] CNT_MAX = {CNT_W{1'b1}};
  localparam logic [CNT_W-1:0] CNT_MIN = '0;

  logic [HIST_W-1:0] lht [LHT_DEPTH];  // local history per key
  logic [CNT_W-1:0]  lpt [LPT_DEPTH];  // 2-bit counters

  logic [HIST_W-1:0] rd_pat_idx;
  logic [HIST_W-1:0] upd_hist_idx;
  logic [HIST_W-1:0] upd_pat_idx;
  logic [CNT_W-1:0]  upd_cnt;
  logic [CNT_W-1:0]  upd_cnt_next;

  assign rd_pat_idx = lht[lookup_key.hist.index];

  always_comb
  begin
    upd_hist_idx = upd.upd_key.hist.index;
    upd_pat_idx  = lht[upd_hist_idx];
    upd_cnt      = lpt[upd_pat_idx];
    upd_cnt_next = upd_cnt;
    if (upd.upd_taken)
    begin
      if (upd_cnt != CNT_MAX)
        upd_cnt_next = upd_cnt + 1'b1;
    end
    else if (upd_cnt != CNT_MIN)
      upd_cnt_next = upd_cnt - 1'b1;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < LHT_DEPTH; i++)
        lht[i] <= '0;
      for (int j = 0; j < LPT_DEPTH; j++)
        lpt[j] <= '0;
      taken <= 1'b0;
    end
    else
    begin
      if (upd.upd_valid)
      begin
        lpt[upd_pat_idx]  <= upd_cnt_next;
        lht[upd_hist_idx] <= {upd.upd_taken, upd_pat_idx[HIST_W-1:1]};  // shift in outcome
      end
      if (lookup_en)
        taken <= lpt[rd_pat_idx][CNT_W-1];
    end
  end

endmodule

`default_nettype wire

//--- design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  localparam int OPCODE_W = 7;  // inst[6:0]
  localparam int KEY_LSB  = 8;  // key is inst[31:8]

  // major opcodes seen by the predictor, everything else folds to op_other
  typedef enum logic [OPCODE_W-1:0] {
    op_other  = 7'b0000000,
    op_branch = 7'b1100011,
    op_jalr   = 7'b1100111,
    op_jal    = 7'b1101111
  } opcode_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the bp_top testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_bp_top -Mdir obj_dir -f bp_predict.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_bp_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "\*\* FAIL \*\*" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failures"
exit 0

//--- testbench/bp_properties.sv
`timescale 1ns/1ns
`default_nettype none

module bp_properties (
  input logic                      clk,
  input logic                      rst,
  input logic                      lookup_valid,
  input logic [bp_pkg::ADDR_W-1:0] lookup_instr,
  input logic                      pred_valid,
  input logic                      pred_taken,
  input logic [bp_pkg::ADDR_W-1:0] pred_target
);
  import rv_isa_pkg::*;

  logic lookup_is_br;

  assign lookup_is_br = lookup_valid &&
                        (lookup_instr[OPCODE_W-1:0] inside {op_branch, op_jal, op_jalr});

  a_target_zero: assert property (@(posedge clk) disable iff (rst)
    !pred_taken |-> (pred_target == '0))
    else $error("pred_target is nonzero while pred_taken is low");

  a_taken_valid: assert property (@(posedge clk) disable iff (rst)
    pred_taken |-> pred_valid)
    else $error("pred_taken is high without pred_valid");

  a_valid_latency: assert property (@(posedge clk) disable iff (rst)
    pred_valid == $past(lookup_is_br))
    else $error("pred_valid does not follow a branch lookup by one cycle");

endmodule

bind bp_top bp_properties u_props (
  .clk          (clk),
  .rst          (rst),
  .lookup_valid (lookup_valid),
  .lookup_instr (lookup_instr),
  .pred_valid   (pred_valid),
  .pred_taken   (pred_taken),
  .pred_target  (pred_target)
);

`default_nettype wire

//--- testbench/tb_bp_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_bp_top;
  localparam int CLK_PERIOD  = 20;
  localparam int RST_CYCLES  = 16;
  localparam int DIR_CYCLES  = 60;  // bound on the directed part
  localparam int RAND_CYCLES = 500;
  localparam int MARGIN      = 50;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_ALU    = 7'b0110011;
  localparam logic [6:0] OPC_SET [4] = '{OPC_BRANCH, OPC_JAL, OPC_JALR, OPC_ALU};
  localparam logic [23:0] KEY_A  = 24'h000405;  // tag 1, index 5
  localparam logic [23:0] KEY_A2 = 24'h000805;  // same index, tag 2
  localparam logic [23:0] KEY_B  = 24'h000c09;
  localparam logic [23:0] KEY_C  = 24'h001002;

  logic        clk = 1'b0;
  logic        rst;
  logic        lookup_valid;
  logic [31:0] lookup_instr;
  logic        resolve_valid;
  logic [31:0] resolve_instr;
  logic        resolve_taken;
  logic [31:0] resolve_target;
  logic        pred_valid;
  logic        pred_taken;
  logic [31:0] pred_target;

  // reference model state
  logic        m_valid  [1024];
  logic [13:0] m_tag    [1024];
  logic [31:0] m_target [1024];
  logic [3:0]  m_hist   [16];
  logic [1:0]  m_cnt    [16];

  logic [33:0] exp_q [$];  // {valid, taken, target}
  logic [33:0] exp_item;
  integer      seed = 32'h08a2_e069;
  int          n_checks = 0;
  int          err_valid = 0;
  int          err_pred = 0;

  bp_top dut0 (.*);

  always #(CLK_PERIOD/2) clk = ~clk;

  function automatic logic [31:0] make_instr(input logic [23:0] key, input logic [6:0] op);
    return {key, 1'b0, op};
  endfunction

  function automatic logic [23:0] small_key(input logic [2:0] sel);
    return {13'd0, sel[2], 8'd0, sel[1:0]};
  endfunction

  function automatic logic [1:0] branch_kind(input logic [31:0] instr);
    if (instr[6:0] == OPC_BRANCH)
      return 2'd1;
    if (instr[6:0] == OPC_JAL || instr[6:0] == OPC_JALR)
      return 2'd2;
    return 2'd0;
  endfunction

  function automatic logic [33:0] predict_ref(input logic lv, input logic [31:0] instr);
    logic [1:0] kind;
    logic [9:0] idx;
    logic [3:0] pat;
    logic       hit;
    logic       tk;
    kind = lv ? branch_kind(instr) : 2'd0;
    idx  = instr[17:8];
    pat  = m_hist[instr[11:8]];
    hit  = m_valid[idx] && (m_tag[idx] == instr[31:18]);
    tk   = (kind == 2'd2) ? hit : ((kind == 2'd1) ? (hit && m_cnt[pat][1]) : 1'b0);
    return {kind != 2'd0, tk, tk ? m_target[idx] : 32'd0};
  endfunction

  task automatic update_ref(input logic [31:0] instr, input logic tk, input logic [31:0] tgt);
    logic [9:0] idx;
    logic [3:0] pat;
    idx = instr[17:8];
    pat = m_hist[instr[11:8]];
    m_valid[idx]  = 1'b1;
    m_tag[idx]    = instr[31:18];
    m_target[idx] = tgt;
    if (tk && m_cnt[pat] != 2'd3)
      m_cnt[pat] = m_cnt[pat] + 2'd1;
    else if (!tk && m_cnt[pat] != 2'd0)
      m_cnt[pat] = m_cnt[pat] - 2'd1;
    m_hist[instr[11:8]] = {tk, pat[3:1]};
  endtask

  task automatic drive_cycle(input logic lv, input logic [31:0] li, input logic rv,
                             input logic [31:0] ri, input logic rt, input logic [31:0] rtg);
    @(posedge clk);
    lookup_valid   <= lv;
    lookup_instr   <= li;
    resolve_valid  <= rv;
    resolve_instr  <= ri;
    resolve_taken  <= rt;
    resolve_target <= rtg;
    exp_q.push_back(predict_ref(lv, li));  // state before this cycle's update
    if (rv && branch_kind(ri) != 2'd0)
      update_ref(ri, rt, rtg);
  endtask

  // outputs for cycle k are stable at the falling edge after cycle k+1 starts
  always @(negedge clk)
  begin
    if (exp_q.size() > 1)
    begin
      exp_item = exp_q.pop_front();
      n_checks++;
      assert (pred_valid == exp_item[33])
      else
      begin
        err_valid++;
        $display("[FAIL] %0t ns: pred_valid %b, expected %b", $time, pred_valid, exp_item[33]);
      end
      assert ({pred_taken, pred_target} == exp_item[32:0])
      else
      begin
        err_pred++;
        $display("[FAIL] %0t ns: prediction %b/%h, expected %b/%h", $time, pred_taken,
                 pred_target, exp_item[32], exp_item[31:0]);
      end
    end
  end

  initial
  begin
    #(CLK_PERIOD * (RST_CYCLES + DIR_CYCLES + RAND_CYCLES + MARGIN));
    $display("timeout: the stimulus did not complete in the expected number of cycles");
    $display("** FAIL **");
    $finish;
  end

  initial
  begin
    logic [31:0] r1;
    logic [31:0] r2;
    for (int i = 0; i < 1024; i++)
    begin
      m_valid[i]  = 1'b0;
      m_tag[i]    = '0;
      m_target[i] = '0;
    end
    for (int i = 0; i < 16; i++)
    begin
      m_hist[i] = '0;
      m_cnt[i]  = '0;
    end
    rst            = 1'b1;
    lookup_valid   = 1'b0;
    lookup_instr   = '0;
    resolve_valid  = 1'b0;
    resolve_instr  = '0;
    resolve_taken  = 1'b0;
    resolve_target = '0;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;

    // lookups on empty tables
    for (int i = 0; i < 4; i++)
      drive_cycle(1'b1, make_instr(KEY_A, OPC_SET[i]), 1'b0, '0, 1'b0, '0);
    // jal hit, then same index with another tag
    drive_cycle(1'b0, '0, 1'b1, make_instr(KEY_A, OPC_JAL), 1'b1, 32'h0000_1a40);
    drive_cycle(1'b1, make_instr(KEY_A, OPC_JAL), 1'b0, '0, 1'b0, '0);
    drive_cycle(1'b1, make_instr(KEY_A2, OPC_JALR), 1'b0, '0, 1'b0, '0);
    // conditional training, then saturation
    for (int i = 0; i < 12; i++)
    begin
      drive_cycle(1'b0, '0, 1'b1, make_instr(KEY_B, OPC_BRANCH), (i < 2) || (i > 3),
                  32'h0000_2200);
      if (i == 1 || i == 3 || i == 11)
        drive_cycle(1'b1, make_instr(KEY_B, OPC_BRANCH), 1'b0, '0, 1'b0, '0);
    end
    // alternating outcomes walk the history
    for (int i = 0; i < 8; i++)
    begin
      drive_cycle(1'b0, '0, 1'b1, make_instr(KEY_C, OPC_BRANCH), i[0], 32'h0000_3000 + i);
      drive_cycle(1'b1, make_instr(KEY_C, OPC_BRANCH), 1'b0, '0, 1'b0, '0);
    end
    // lookup and resolve together
    drive_cycle(1'b1, make_instr(KEY_B, OPC_BRANCH), 1'b1, make_instr(KEY_B, OPC_BRANCH),
                1'b1, 32'h0000_4400);
    drive_cycle(1'b1, make_instr(KEY_B, OPC_BRANCH), 1'b0, '0, 1'b0, '0);

    for (int i = 0; i < RAND_CYCLES; i++)
    begin
      r1 = $random(seed);
      r2 = $random(seed);
      drive_cycle(r1[0], make_instr(small_key(r1[3:1]), OPC_SET[r1[5:4]]), r1[6],
                  make_instr(small_key(r1[9:7]), OPC_SET[r1[11:10]]), r1[12], r2);
    end
    drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);  // flush the last result
    drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
    @(posedge clk);  // past the last compare

    $display("checks %0d, valid errors %0d, prediction errors %0d",
             n_checks, err_valid, err_pred);
    if (err_valid + err_pred == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire
